// ==== rtl/l2_pkg.sv ====
// L2 tile memory shared constants for the AXI4-Lite port and the mailbox
package l2_pkg;

  // AXI4-Lite port geometry
  localparam int unsigned AXI_ADDR_W = 32;
  localparam int unsigned AXI_DATA_W = 32;
  localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;

  // Mailbox locations, outside the aliased memory map
  // Exit code, a nonzero write ends the computation
  localparam logic [AXI_ADDR_W-1:0] MBOX_EXIT_ADDR = 32'hFFFF_0000;
  // Stdout character, low byte of the written word
  localparam logic [AXI_ADDR_W-1:0] MBOX_STDOUT_ADDR = 32'hFFFF_0004;

  // Only response the port ever gives
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

// ==== rtl/l2_axil_frontend.sv ====
// AXI4-Lite slave front end: accepts one transaction, decodes it and drives banks or mailbox
`timescale 1ns/1ps

module l2_axil_frontend import l2_pkg::*; #(
  parameter int unsigned NUM_BANKS  = 4,
  parameter int unsigned BANK_DEPTH = 64,
  // Derived widths, NUM_BANKS must be at least 2
  localparam int unsigned BANK_W = $clog2(NUM_BANKS),
  localparam int unsigned ROW_W  = $clog2(BANK_DEPTH)
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  // AW channel
  input  logic [AXI_ADDR_W-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  // W channel
  input  logic [AXI_DATA_W-1:0] wdata_i,
  input  logic [AXI_STRB_W-1:0] wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  // B channel
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  // AR channel
  input  logic [AXI_ADDR_W-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  // Bank requests
  output logic [NUM_BANKS-1:0]  bank_we_o,
  output logic [NUM_BANKS-1:0]  bank_re_o,
  output logic [ROW_W-1:0]      bank_row_o,
  output logic [AXI_DATA_W-1:0] bank_wdata_o,
  output logic [AXI_STRB_W-1:0] bank_wstrb_o,
  // Mailbox writes
  output logic                  mb_exit_we_o,
  output logic                  mb_stdout_we_o,
  // Read collector handshake
  output logic                  rd_issue_o,
  output logic [BANK_W-1:0]     rd_bank_o,
  output logic [1:0]            rd_mbox_o,
  input  logic                  rd_done_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WR_COLLECT,
    ST_WR_RESP,
    ST_RD_WAIT
  } state_e;

  state_e state_q;

  // Registered channel readies, low out of reset
  logic awready_q;
  logic wready_q;
  logic arready_q;
  // Per-channel latch flags, AW and W arrive in any order
  logic aw_got_q;
  logic w_got_q;
  logic bvalid_q;
  // One-cycle write pulse, lines up with the rise of bvalid
  logic wr_fire_q;

  // Latched write payload
  logic [AXI_ADDR_W-1:0] awaddr_q;
  logic [AXI_DATA_W-1:0] wdata_q;
  logic [AXI_STRB_W-1:0] wstrb_q;

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic wr_both;

  logic              wr_is_exit;
  logic              wr_is_stdout;
  logic [BANK_W-1:0] wr_bank;
  logic [ROW_W-1:0]  wr_row;
  logic              ar_is_exit;
  logic              ar_is_stdout;
  logic [BANK_W-1:0] ar_bank;
  logic [ROW_W-1:0]  ar_row;

  // Handshakes
  assign awready_o = awready_q;
  assign wready_o  = wready_q;
  // A pending write beats a read offered in the same cycle
  assign arready_o = arready_q & ~awvalid_i & ~wvalid_i;

  assign aw_hs = awvalid_i & awready_o;
  assign w_hs  = wvalid_i & wready_o;
  assign ar_hs = arvalid_i & arready_o;

  // Both halves of the write present by the end of this cycle
  assign wr_both = (aw_got_q | aw_hs) & (w_got_q | w_hs);

  // Word interleave: bank from the low word bits, row above them
  assign wr_is_exit   = (awaddr_q == MBOX_EXIT_ADDR);
  assign wr_is_stdout = (awaddr_q == MBOX_STDOUT_ADDR);
  assign wr_bank      = awaddr_q[2 +: BANK_W];
  assign wr_row       = awaddr_q[2 + BANK_W +: ROW_W];

  assign ar_is_exit   = (araddr_i == MBOX_EXIT_ADDR);
  assign ar_is_stdout = (araddr_i == MBOX_STDOUT_ADDR);
  assign ar_bank      = araddr_i[2 +: BANK_W];
  assign ar_row       = araddr_i[2 + BANK_W +: ROW_W];

  // Control FSM
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      arready_q <= 1'b0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      bvalid_q  <= 1'b0;
      wr_fire_q <= 1'b0;
    end else begin
      wr_fire_q <= 1'b0;
      case (state_q)
        ST_IDLE, ST_WR_COLLECT: begin
          if (wr_both) begin
            // Write goes out next cycle together with bvalid
            state_q   <= ST_WR_RESP;
            wr_fire_q <= 1'b1;
            bvalid_q  <= 1'b1;
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            arready_q <= 1'b0;
            aw_got_q  <= 1'b0;
            w_got_q   <= 1'b0;
          end else if (aw_hs || w_hs) begin
            // Half a write, keep waiting for the other channel
            state_q   <= ST_WR_COLLECT;
            aw_got_q  <= aw_got_q | aw_hs;
            w_got_q   <= w_got_q | w_hs;
            awready_q <= awready_q & ~aw_hs;
            wready_q  <= wready_q & ~w_hs;
            arready_q <= 1'b0;
          end else if (ar_hs) begin
            state_q   <= ST_RD_WAIT;
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            arready_q <= 1'b0;
          end else if (state_q == ST_IDLE) begin
            // Opens the port after reset
            awready_q <= 1'b1;
            wready_q  <= 1'b1;
            arready_q <= 1'b1;
          end
        end
        ST_WR_RESP: begin
          if (bready_i) begin
            state_q   <= ST_IDLE;
            bvalid_q  <= 1'b0;
            awready_q <= 1'b1;
            wready_q  <= 1'b1;
            arready_q <= 1'b1;
          end
        end
        ST_RD_WAIT: begin
          // Collector signals the R handshake
          if (rd_done_i) begin
            state_q   <= ST_IDLE;
            awready_q <= 1'b1;
            wready_q  <= 1'b1;
            arready_q <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Payload capture on each channel handshake
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      awaddr_q <= awaddr_i;
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
  end

  // B channel
  assign bvalid_o = bvalid_q;
  assign bresp_o  = AXI_RESP_OKAY;

  // Bank side, row is shared and follows the read in its AR cycle
  assign bank_we_o    = (wr_fire_q && !wr_is_exit && !wr_is_stdout) ?
                        (NUM_BANKS'(1) << wr_bank) : '0;
  assign bank_re_o    = (ar_hs && !ar_is_exit && !ar_is_stdout) ?
                        (NUM_BANKS'(1) << ar_bank) : '0;
  assign bank_row_o   = ar_hs ? ar_row : wr_row;
  assign bank_wdata_o = wdata_q;
  assign bank_wstrb_o = wstrb_q;

  // Mailbox writes take the full word
  assign mb_exit_we_o   = wr_fire_q & wr_is_exit;
  assign mb_stdout_we_o = wr_fire_q & wr_is_stdout;

  // Read issue, bit 0 selects exit code and bit 1 the stdout slot
  assign rd_issue_o = ar_hs;
  assign rd_bank_o  = ar_bank;
  assign rd_mbox_o  = {ar_is_stdout, ar_is_exit};

endmodule

// ==== rtl/l2_bank.sv ====
// Single-port word SRAM bank with byte write strobes and registered read data
`timescale 1ns/1ps

module l2_bank import l2_pkg::*; #(
  parameter int unsigned BANK_DEPTH = 64,
  localparam int unsigned ROW_W = $clog2(BANK_DEPTH)
) (
  input  logic                  clk,
  input  logic                  we_i,
  input  logic                  re_i,
  input  logic [ROW_W-1:0]      row_i,
  input  logic [AXI_DATA_W-1:0] wdata_i,
  input  logic [AXI_STRB_W-1:0] wstrb_i,
  output logic [AXI_DATA_W-1:0] rdata_o
);

  // Storage array, contents undefined after reset
  logic [AXI_DATA_W-1:0] mem_q [BANK_DEPTH];

  // Byte-wise write, untouched lanes keep their old value
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem_q[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read port
  // Output holds its last word between reads
  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_o <= mem_q[row_i];
    end
  end

endmodule

// ==== rtl/l2_rd_collect.sv ====
// Read-return collector: aligns the bank select, picks the word and drives the R channel
`timescale 1ns/1ps

module l2_rd_collect import l2_pkg::*; #(
  parameter int unsigned NUM_BANKS = 4,
  localparam int unsigned BANK_W = $clog2(NUM_BANKS)
) (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            rd_issue_i,
  input  logic [BANK_W-1:0]               rd_bank_i,
  input  logic [1:0]                      rd_mbox_i,
  input  logic [NUM_BANKS*AXI_DATA_W-1:0] bank_rdata_i,
  input  logic [AXI_DATA_W-1:0]           mbox_rdata_i,
  output logic [AXI_DATA_W-1:0]           rdata_o,
  output logic [1:0]                      rresp_o,
  output logic                            rvalid_o,
  input  logic                            rready_i,
  output logic                            rd_done_o
);

  // Bank data is valid one cycle after the issue
  logic                  pend_q;
  logic                  rvalid_q;
  logic [BANK_W-1:0]     sel_bank_q;
  logic [1:0]            sel_mbox_q;
  logic [AXI_DATA_W-1:0] rdata_q;
  logic [AXI_DATA_W-1:0] rd_word;

  // Source select: exit code, stdout slot reads as zero, else the bank
  always_comb begin
    if (sel_mbox_q[0]) begin
      rd_word = mbox_rdata_i;
    end else if (sel_mbox_q[1]) begin
      rd_word = '0;
    end else begin
      rd_word = bank_rdata_i[sel_bank_q*AXI_DATA_W +: AXI_DATA_W];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pend_q   <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      pend_q <= rd_issue_i;
      if (pend_q) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Selection and return word
  always_ff @(posedge clk) begin
    if (rd_issue_i) begin
      sel_bank_q <= rd_bank_i;
      sel_mbox_q <= rd_mbox_i;
    end
    // Held stable while the master stalls
    if (pend_q) begin
      rdata_q <= rd_word;
    end
  end

  assign rdata_o   = rdata_q;
  assign rresp_o   = AXI_RESP_OKAY;
  assign rvalid_o  = rvalid_q;
  assign rd_done_o = rvalid_q & rready_i;

endmodule

// ==== rtl/l2_mailbox.sv ====
// Host mailbox: exit code register, sticky end-of-computation flag and stdout strobe
`timescale 1ns/1ps

module l2_mailbox import l2_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  exit_we_i,
  input  logic                  stdout_we_i,
  input  logic [AXI_DATA_W-1:0] wdata_i,
  output logic [AXI_DATA_W-1:0] exit_code_o,
  output logic                  eoc_o,
  output logic [7:0]            char_o,
  output logic                  char_valid_o
);

  logic [AXI_DATA_W-1:0] exit_code_q;
  logic                  eoc_q;

  // Exit code and EOC
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      exit_code_q <= '0;
      eoc_q       <= 1'b0;
    end else if (exit_we_i) begin
      exit_code_q <= wdata_i;
      // Zero is stored but does not end the run
      if (wdata_i != '0) begin
        eoc_q <= 1'b1;
      end
    end
  end

  assign exit_code_o = exit_code_q;
  assign eoc_o       = eoc_q;

  // Stdout, strobe comes straight from the one-cycle write pulse
  assign char_valid_o = stdout_we_i;
  assign char_o       = wdata_i[7:0];

endmodule

// ==== rtl/l2_tile_mem.sv ====
// L2 tile memory top: AXI4-Lite front end, interleaved SRAM banks, read collector, mailbox
`timescale 1ns/1ps

module l2_tile_mem import l2_pkg::*; #(
  parameter int unsigned NUM_BANKS  = 4,
  parameter int unsigned BANK_DEPTH = 64,
  localparam int unsigned BANK_W = $clog2(NUM_BANKS),
  localparam int unsigned ROW_W  = $clog2(BANK_DEPTH)
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  // AXI4-Lite slave
  input  logic [AXI_ADDR_W-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  logic [AXI_DATA_W-1:0] wdata_i,
  input  logic [AXI_STRB_W-1:0] wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  input  logic [AXI_ADDR_W-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output logic [AXI_DATA_W-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  // Mailbox
  output logic                  eoc_o,
  output logic [AXI_DATA_W-1:0] exit_code_o,
  output logic [7:0]            char_o,
  output logic                  char_valid_o
);

  // Front end to banks
  logic [NUM_BANKS-1:0]            bank_we;
  logic [NUM_BANKS-1:0]            bank_re;
  logic [ROW_W-1:0]                bank_row;
  logic [AXI_DATA_W-1:0]           bank_wdata;
  logic [AXI_STRB_W-1:0]           bank_wstrb;
  logic [NUM_BANKS*AXI_DATA_W-1:0] bank_rdata;
  // Front end to mailbox and collector
  logic                            mb_exit_we;
  logic                            mb_stdout_we;
  logic                            rd_issue;
  logic [BANK_W-1:0]               rd_bank;
  logic [1:0]                      rd_mbox;
  logic                            rd_done;

  l2_axil_frontend #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) u_frontend (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .awaddr_i       (awaddr_i),
    .awvalid_i      (awvalid_i),
    .awready_o      (awready_o),
    .wdata_i        (wdata_i),
    .wstrb_i        (wstrb_i),
    .wvalid_i       (wvalid_i),
    .wready_o       (wready_o),
    .bresp_o        (bresp_o),
    .bvalid_o       (bvalid_o),
    .bready_i       (bready_i),
    .araddr_i       (araddr_i),
    .arvalid_i      (arvalid_i),
    .arready_o      (arready_o),
    .bank_we_o      (bank_we),
    .bank_re_o      (bank_re),
    .bank_row_o     (bank_row),
    .bank_wdata_o   (bank_wdata),
    .bank_wstrb_o   (bank_wstrb),
    .mb_exit_we_o   (mb_exit_we),
    .mb_stdout_we_o (mb_stdout_we),
    .rd_issue_o     (rd_issue),
    .rd_bank_o      (rd_bank),
    .rd_mbox_o      (rd_mbox),
    .rd_done_i      (rd_done)
  );

  // Word-interleaved banks, each returns its slice of the flat read bus
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    l2_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) u_bank (
      .clk     (clk),
      .we_i    (bank_we[g]),
      .re_i    (bank_re[g]),
      .row_i   (bank_row),
      .wdata_i (bank_wdata),
      .wstrb_i (bank_wstrb),
      .rdata_o (bank_rdata[g*AXI_DATA_W +: AXI_DATA_W])
    );
  end

  l2_rd_collect #(
    .NUM_BANKS (NUM_BANKS)
  ) u_rd_collect (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .rd_issue_i   (rd_issue),
    .rd_bank_i    (rd_bank),
    .rd_mbox_i    (rd_mbox),
    .bank_rdata_i (bank_rdata),
    .mbox_rdata_i (exit_code_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .rd_done_o    (rd_done)
  );

  // Mailbox takes the latched write word from the front end
  l2_mailbox u_mailbox (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .exit_we_i    (mb_exit_we),
    .stdout_we_i  (mb_stdout_we),
    .wdata_i      (bank_wdata),
    .exit_code_o  (exit_code_o),
    .eoc_o        (eoc_o),
    .char_o       (char_o),
    .char_valid_o (char_valid_o)
  );

endmodule

// ==== tests/l2_tile_mem_assertions.sv ====
// Bound checks on the L2 tile memory for response stability, stdout strobe, bank reads and EOC
`timescale 1ns/1ps

module l2_tile_mem_assertions import l2_pkg::*; #(
  parameter int unsigned NUM_BANKS = 4
) (
  input logic                  clk,
  input logic                  rst_n_i,
  input logic                  bvalid_i,
  input logic                  bready_i,
  input logic                  rvalid_i,
  input logic                  rready_i,
  input logic [AXI_DATA_W-1:0] rdata_i,
  input logic                  char_valid_i,
  input logic                  eoc_i,
  input logic [NUM_BANKS-1:0]  bank_re_i
);

  // Number of assertion failures so far
  int fail_cnt = 0;

  // B channel holds until bready
  b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("bvalid fell before bready");
      fail_cnt++;
    end

  // R channel holds word and valid until rready
  r_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else begin
      $error("rvalid or rdata changed before rready");
      fail_cnt++;
    end

  // Stdout strobe is a single-cycle pulse
  char_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    char_valid_i |=> !char_valid_i)
    else begin
      $error("char_valid high for two cycles");
      fail_cnt++;
    end

  // At most one bank reads per cycle
  re_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0(bank_re_i))
    else begin
      $error("more than one bank read enable set");
      fail_cnt++;
    end

  // EOC stays high until reset
  eoc_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
    eoc_i |=> eoc_i)
    else begin
      $error("eoc fell without reset");
      fail_cnt++;
    end

endmodule

bind l2_tile_mem l2_tile_mem_assertions #(
  .NUM_BANKS (NUM_BANKS)
) u_chk (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .bvalid_i     (bvalid_o),
  .bready_i     (bready_i),
  .rvalid_i     (rvalid_o),
  .rready_i     (rready_i),
  .rdata_i      (rdata_o),
  .char_valid_i (char_valid_o),
  .eoc_i        (eoc_o),
  .bank_re_i    (bank_re)
);

// ==== tests/tb_l2_tile_mem.sv ====
// Testbench for the L2 tile memory with random AXI4-Lite traffic checked against a word model
`timescale 1ns/1ps

module tb_l2_tile_mem import l2_pkg::*; ();

  localparam int NUM_BANKS   = 4;
  localparam int BANK_DEPTH  = 64;
  localparam int MODEL_WORDS = NUM_BANKS * BANK_DEPTH;
  // Transactions per test
  localparam int N_BASIC = 200;
  localparam int N_MERGE = 60;
  localparam int N_ALIAS = 20;
  localparam int N_GROUP = 8;
  localparam int N_STALL = 40;
  localparam int N_CHAR  = 8;
  localparam int TOTAL_TXN = 2 * N_BASIC + 3 * N_MERGE + 4 * N_ALIAS + 8 * N_GROUP
                             + 2 * N_STALL + 2 * N_CHAR + 6;
  // Budget of 20 clocks per transaction even with a full stall, plus the reset cycles
  localparam longint WATCHDOG_NS = (longint'(TOTAL_TXN) * 20 + 16) * 8;

  logic                  clk;
  logic                  rst_n_i;
  logic [AXI_ADDR_W-1:0] awaddr_i;
  logic                  awvalid_i;
  logic                  awready_o;
  logic [AXI_DATA_W-1:0] wdata_i;
  logic [AXI_STRB_W-1:0] wstrb_i;
  logic                  wvalid_i;
  logic                  wready_o;
  logic [1:0]            bresp_o;
  logic                  bvalid_o;
  logic                  bready_i;
  logic [AXI_ADDR_W-1:0] araddr_i;
  logic                  arvalid_i;
  logic                  arready_o;
  logic [AXI_DATA_W-1:0] rdata_o;
  logic [1:0]            rresp_o;
  logic                  rvalid_o;
  logic                  rready_i;
  logic                  eoc_o;
  logic [AXI_DATA_W-1:0] exit_code_o;
  logic [7:0]            char_o;
  logic                  char_valid_o;

  // Reference memory with one entry per aliased word
  logic [31:0] model_mem [MODEL_WORDS];
  bit          model_vld [MODEL_WORDS];

  logic [31:0] lfsr_state = 32'h2462_9515;
  int          cyc = 0;
  int          err_cnt = 0;
  int          test_base = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;

  l2_tile_mem #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Cycle count, read at the falling edge
  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Random word-aligned address outside the mailbox page
  function automatic logic [31:0] pick_addr();
    logic [31:0] a;
    a = take_bits(32);
    a[1:0] = 2'b00;
    if (a[31:16] == 16'hFFFF) begin
      a[31] = 1'b0;
    end
    return a;
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'(addr[31:2] % MODEL_WORDS);
  endfunction

  // Strobed bytes replace the old ones and the rest keep their value
  function automatic void model_update(input logic [31:0] addr, input logic [31:0] data,
                                       input logic [3:0] strb);
    int idx;
    idx = word_index(addr);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model_mem[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
    model_vld[idx] = 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("ERR time=%0t signal=%s expected=0x%08h observed=0x%08h", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic start_test();
    test_base = err_cnt;
  endtask

  task automatic report_test(input string name);
    int n;
    n = err_cnt - test_base;
    if (n == 0) begin
      tests_pass++;
      $display("PASS  %s", name);
    end else begin
      tests_fail++;
      $display("FAIL  %s (%0d errors)", name, n);
    end
  endtask

  // Outputs that must be low in and right after reset
  task automatic check_quiet();
    check_value("awready", 0, 32'(awready_o));
    check_value("wready", 0, 32'(wready_o));
    check_value("arready", 0, 32'(arready_o));
    check_value("bvalid", 0, 32'(bvalid_o));
    check_value("rvalid", 0, 32'(rvalid_o));
    check_value("eoc", 0, 32'(eoc_o));
    check_value("char_valid", 0, 32'(char_valid_o));
  endtask

  function automatic logic [31:0] payload(input bit is_write);
    return is_write ? 32'(bresp_o) : rdata_o;
  endfunction

  function automatic logic resp_valid(input bit is_write);
    return is_write ? bvalid_o : rvalid_o;
  endfunction

  // Entered at the negedge where valid first shows
  // Stalls for the given cycles and then takes the response
  task automatic hold_and_accept(input int stall, input bit is_write);
    logic [31:0] first;
    first = payload(is_write);
    for (int k = 0; k <= stall; k++) begin
      check_value("valid under stall", 1, 32'(resp_valid(is_write)));
      check_value("payload under stall", first, payload(is_write));
      // No channel open while a response waits
      check_value("readies under stall", 0, 32'({awready_o, wready_o, arready_o}));
      @(posedge clk);
      #1;
      bready_i = is_write && (k == stall);
      rready_i = !is_write && (k == stall);
      @(negedge clk);
    end
    check_value("valid at handshake", 1, 32'(resp_valid(is_write)));
    check_value("payload at handshake", first, payload(is_write));
    @(posedge clk);
    #1;
    bready_i = 1'b0;
    rready_i = 1'b0;
    @(negedge clk);
    check_value("valid after handshake", 0, 32'(resp_valid(is_write)));
  endtask

  // Order 0 offers AW and W together, 1 leads with AW, 2 leads with W
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int order, input int stall);
    bit                   aw_done;
    bit                   w_done;
    bit                   is_stdout;
    bit                   is_mbox;
    int                   hs_cyc;
    logic [NUM_BANKS-1:0] exp_we;
    aw_done   = 1'b0;
    w_done    = 1'b0;
    hs_cyc    = 0;
    is_stdout = (addr == MBOX_STDOUT_ADDR);
    is_mbox   = is_stdout || (addr == MBOX_EXIT_ADDR);
    exp_we    = is_mbox ? '0 : NUM_BANKS'(1) << (word_index(addr) % NUM_BANKS);
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      #1;
      awaddr_i  = addr;
      wdata_i   = data;
      wstrb_i   = strb;
      awvalid_i = !aw_done && (order != 2 || w_done);
      wvalid_i  = !w_done && (order != 1 || aw_done);
      @(negedge clk);
      if (awvalid_i && awready_o) begin
        aw_done = 1'b1;
        hs_cyc  = cyc;
      end
      if (wvalid_i && wready_o) begin
        w_done = 1'b1;
        hs_cyc = cyc;
      end
    end
    do begin
      @(posedge clk);
      #1;
      awvalid_i = 1'b0;
      wvalid_i  = 1'b0;
      @(negedge clk);
    end while (!bvalid_o);
    // Later handshake plus one
    check_value("bvalid latency", 1, cyc - hs_cyc);
    check_value("bresp", 32'(AXI_RESP_OKAY), 32'(bresp_o));
    check_value("char_valid", 32'(is_stdout), 32'(char_valid_o));
    if (is_stdout) begin
      check_value("char", 32'(data[7:0]), 32'(char_o));
    end
    // Bank chosen by word index modulo bank count
    check_value("bank_we", 32'(exp_we), 32'(UUT.bank_we));
    if (!is_mbox) begin
      model_update(addr, data, strb);
    end
    hold_and_accept(stall, 1'b1);
  endtask

  task automatic read_check(input logic [31:0] addr, input int stall, input logic [31:0] exp);
    bit done;
    int hs_cyc;
    done   = 1'b0;
    hs_cyc = 0;
    while (!done) begin
      @(posedge clk);
      #1;
      araddr_i  = addr;
      arvalid_i = 1'b1;
      @(negedge clk);
      if (arready_o) begin
        done   = 1'b1;
        hs_cyc = cyc;
      end
    end
    do begin
      @(posedge clk);
      #1;
      arvalid_i = 1'b0;
      @(negedge clk);
    end while (!rvalid_o);
    // Bank register then collector register
    check_value("rvalid latency", 2, cyc - hs_cyc);
    check_value("rresp", 32'(AXI_RESP_OKAY), 32'(rresp_o));
    check_value("rdata", exp, rdata_o);
    hold_and_accept(stall, 1'b0);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [3:0]  s;
    rst_n_i   = 1'b0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;

    // Reset held low for 8 edges with outputs checked on both sides of release
    start_test();
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_quiet();
    @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk);
    check_quiet();
    for (int i = 0; i < N_BASIC; i++) begin
      a = pick_addr();
      write_word(a, take_bits(32), 4'hF, 0, 0);
      read_check(a, 0, model_mem[word_index(a)]);
    end
    report_test("reset and full-word readback");

    start_test();
    for (int i = 0; i < N_MERGE; i++) begin
      a = pick_addr();
      // Known base word before merging
      if (!model_vld[word_index(a)]) begin
        write_word(a, take_bits(32), 4'hF, 0, 0);
      end
      d = take_bits(32);
      s = 4'(take_bits(4));
      write_word(a, d, s, 0, 0);
      read_check(a, 0, model_mem[word_index(a)]);
    end
    report_test("partial strobe merge");

    start_test();
    for (int i = 0; i < N_ALIAS; i++) begin
      a = pick_addr();
      // Offset by a nonzero multiple of 1 KiB
      b = a + ((take_bits(22) | 32'd1) << 10);
      if (b[31:16] == 16'hFFFF) begin
        b[31] = 1'b0;
      end
      write_word(a, take_bits(32), 4'hF, 0, 0);
      read_check(b, 0, model_mem[word_index(a)]);
      write_word(b, take_bits(32), 4'hF, 0, 0);
      read_check(a, 0, model_mem[word_index(b)]);
    end
    // Four consecutive words land in four different banks
    for (int g = 0; g < N_GROUP; g++) begin
      a = pick_addr() & ~32'hF;
      for (int k = 0; k < 4; k++) begin
        write_word(a + 32'(4 * k), take_bits(32), 4'hF, 0, 0);
      end
      for (int k = 0; k < 4; k++) begin
        read_check(a + 32'(4 * k), 0, model_mem[word_index(a + 32'(4 * k))]);
      end
    end
    report_test("aliasing and bank interleave");

    start_test();
    for (int i = 0; i < N_STALL; i++) begin
      a = pick_addr();
      write_word(a, take_bits(32), 4'hF, 1 + int'(take_bits(1)), int'(take_bits(3)));
      read_check(a, int'(take_bits(3)), model_mem[word_index(a)]);
    end
    report_test("back-pressure and latency");

    start_test();
    for (int i = 0; i < N_CHAR; i++) begin
      // Strobes do not matter for the mailbox
      s = 4'(take_bits(4));
      write_word(MBOX_STDOUT_ADDR, take_bits(32), s, 0, int'(take_bits(3)));
      read_check(MBOX_STDOUT_ADDR, 0, 32'h0);
    end
    check_value("eoc", 0, 32'(eoc_o));
    report_test("stdout character");

    start_test();
    write_word(MBOX_EXIT_ADDR, 32'h0, 4'hF, 0, 0);
    check_value("eoc", 0, 32'(eoc_o));
    check_value("exit_code", 0, exit_code_o);
    read_check(MBOX_EXIT_ADDR, 0, 32'h0);
    d = take_bits(32) | 32'd1;
    write_word(MBOX_EXIT_ADDR, d, 4'h1, 0, 0);
    check_value("eoc", 1, 32'(eoc_o));
    check_value("exit_code", d, exit_code_o);
    read_check(MBOX_EXIT_ADDR, 0, d);
    // A later zero is stored and eoc stays high
    write_word(MBOX_EXIT_ADDR, 32'h0, 4'hF, 0, 0);
    check_value("eoc", 1, 32'(eoc_o));
    check_value("exit_code", 0, exit_code_o);
    read_check(MBOX_EXIT_ADDR, 0, 32'h0);
    report_test("exit code and eoc");

    check_value("assertion failures", 0, 32'(UUT.u_chk.fail_cnt));
    $display("Tests passed: %0d  failed: %0d  errors: %0d", tests_pass, tests_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
rtl/l2_pkg.sv
rtl/l2_axil_frontend.sv
rtl/l2_bank.sv
rtl/l2_rd_collect.sv
rtl/l2_mailbox.sv
rtl/l2_tile_mem.sv
tests/l2_tile_mem_assertions.sv
tests/tb_l2_tile_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the L2 tile memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_l2_tile_mem --Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_l2_tile_mem +verilator+error+limit+1000 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -qx "Simulation passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
